/* Makefile */
# Verilator flow for the serial register-access master.
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= uart_cmd_tb
RTL_TOP    ?= uart_cmd_top
FILE_LIST  ?= list.f
RTL_SRCS   ?= $(shell grep '^design/' $(FILE_LIST))
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Checks failed
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/uart_cmd_tb.sv */
module uart_cmd_tb;
  import uart_cmd_pkg::*;

  // Worst single transaction is two frames plus the gap or the reply timeout.
  localparam int TXN_CLKS   = 2 * FRAME_BITS * CLKS_PER_BIT + GAP_CLKS + REPLY_TIMEOUT_CLKS;
  localparam int NUM_TXN    = 40;
  localparam int MAX_CYCLES = 2 * NUM_TXN * TXN_CLKS;

  logic   clk;
  logic   rst_n;
  cmd_t   cmd_in;
  logic   cmd_vld;
  logic   cmd_rdy;
  logic   rx;
  logic   tx;
  byte_t  read_data;
  logic   read_rdy;
  logic   read_err;
  logic   corrupt_parity;
  logic   mute;
  int     frame_count;
  int     parity_err_count;
  int     error_count;
  int     cycle_count;
  integer seed;
  byte_t  exp_regs [0:7];

  uart_cmd_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_reg_model u_model (
    .clk              (clk),
    .from_master      (tx),
    .corrupt_parity   (corrupt_parity),
    .mute             (mute),
    .to_master        (rx),
    .frame_count      (frame_count),
    .parity_err_count (parity_err_count)
  );

  always #20 clk = ~clk;

  // ============================================================
  // Transaction tasks.
  // ============================================================

  task automatic send_cmd(input logic is_write, input addr_t addr, input byte_t data);
    while (!cmd_rdy)
      @(negedge clk);
    cmd_in.write = is_write;
    cmd_in.addr  = addr;
    cmd_in.data  = data;
    cmd_vld      = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic write_reg(input addr_t addr, input byte_t data);
    send_cmd(1'b1, addr, data);
    while (!cmd_rdy)
      @(negedge clk);
    exp_regs[addr[2:0]] = data;
  endtask

  task automatic read_and_check(input addr_t addr, input logic exp_err);
    byte_t exp_data;
    exp_data = exp_regs[addr[2:0]];
    send_cmd(1'b0, addr, 8'h00);
    while (!read_rdy)
      @(negedge clk);
    if (read_err !== exp_err)
    begin
      $display("** Error at %0t: read of addr %0d gave read_err %b, expected %b",
               $time, addr, read_err, exp_err);
      error_count++;
    end
    if (!exp_err && read_data !== exp_data)
    begin
      $display("** Error at %0t: read of addr %0d gave 8'h%h, expected 8'h%h",
               $time, addr, read_data, exp_data);
      error_count++;
    end
  endtask

  // ============================================================
  // Directed tests.
  // ============================================================

  task automatic test_reset();
    if (tx !== 1'b1 || cmd_rdy !== 1'b1 || read_rdy !== 1'b0)
    begin
      $display("** Error at %0t: after reset tx=%b cmd_rdy=%b read_rdy=%b",
               $time, tx, cmd_rdy, read_rdy);
      error_count++;
    end
    if (read_err !== 1'b0 || read_data !== 8'h00)
    begin
      $display("** Error at %0t: after reset read_err=%b read_data=8'h%h",
               $time, read_err, read_data);
      error_count++;
    end
    if (frame_count != 0)
    begin
      $display("** Error at %0t: model saw %0d frames before any command", $time, frame_count);
      error_count++;
    end
  endtask

  task automatic test_write_read();
    int frames_start;
    frames_start = frame_count;
    write_reg(7'd5, 8'hA5);
    if (frame_count - frames_start != 2)
    begin
      $display("** Error at %0t: write sent %0d frames, expected 2",
               $time, frame_count - frames_start);
      error_count++;
    end
    read_and_check(7'd5, 1'b0);
    if (frame_count - frames_start != 3)
    begin
      $display("** Error at %0t: write and read sent %0d frames, expected 3",
               $time, frame_count - frames_start);
      error_count++;
    end
    if (parity_err_count != 0)
    begin
      $display("** Error at %0t: model saw %0d parity errors", $time, parity_err_count);
      error_count++;
    end
  endtask

  task automatic test_random();
    int     i;
    integer r;
    addr_t  addr;
    // First eight writes cover every address once.
    for (i = 0; i < 20; i++)
    begin
      r    = $random(seed);
      addr = (i < 8) ? addr_t'(i) : addr_t'(r[2:0]);
      write_reg(addr, r[15:8]);
    end
    for (i = 0; i < 8; i++)
      read_and_check(addr_t'(i), 1'b0);
  endtask

  task automatic test_parity_error();
    corrupt_parity = 1'b1;
    read_and_check(7'd3, 1'b1);
    corrupt_parity = 1'b0;
    read_and_check(7'd3, 1'b0);
  endtask

  task automatic test_timeout();
    mute = 1'b1;
    read_and_check(7'd2, 1'b1);
    @(negedge clk);
    if (cmd_rdy !== 1'b1)
    begin
      $display("** Error at %0t: cmd_rdy=%b one clock after timed-out read", $time, cmd_rdy);
      error_count++;
    end
    mute = 1'b0;
  endtask

  task automatic test_dropped_cmd();
    int frames_start;
    write_reg(7'd6, 8'h3C);
    frames_start = frame_count;
    send_cmd(1'b1, 7'd1, 8'h99);
    // A second write to address 6 is held while the first is still on the wire.
    cmd_in.write = 1'b1;
    cmd_in.addr  = 7'd6;
    cmd_in.data  = 8'hC3;
    cmd_vld      = 1'b1;
    repeat (4 * CLKS_PER_BIT) @(negedge clk);
    cmd_vld = 1'b0;
    while (!cmd_rdy)
      @(negedge clk);
    exp_regs[1] = 8'h99;
    if (frame_count - frames_start != 2)
    begin
      $display("** Error at %0t: %0d frames sent with a dropped command, expected 2",
               $time, frame_count - frames_start);
      error_count++;
    end
    read_and_check(7'd6, 1'b0);
    read_and_check(7'd1, 1'b0);
  endtask

  // ============================================================
  // Run control.
  // ============================================================

  initial
  begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    cmd_in         = '0;
    cmd_vld        = 1'b0;
    corrupt_parity = 1'b0;
    mute           = 1'b0;
    error_count    = 0;
    seed           = 32'hcf34;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_write_read();
    test_random();
    test_parity_error();
    test_timeout();
    test_dropped_cmd();
    $display("Summary: %0d errors after %0d cycles", error_count, cycle_count);
    if (error_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: tests still running after %0d clock cycles", MAX_CYCLES);
    $display("Summary: %0d errors before the timeout", error_count);
    $display("Checks failed");
    $finish;
  end

endmodule

/* bench/uart_reg_model.sv */
module uart_reg_model (
  input  logic clk,
  input  logic from_master,
  input  logic corrupt_parity,
  input  logic mute,
  output logic to_master,
  output int   frame_count,
  output int   parity_err_count
);
  import uart_cmd_pkg::*;

  byte_t regs [0:127];
  logic  armed;
  addr_t wr_addr;
  byte_t reply_byte;
  event  reply_ev;

  // Data bits arrive LSB first, so each one shifts in from the top.
  task automatic recv_frame(output byte_t data, output logic par);
    data = '0;
    repeat (8)
    begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      data = {from_master, data[7:1]};
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    par = from_master;
    repeat (CLKS_PER_BIT) @(posedge clk);
  endtask

  task automatic send_frame(input byte_t data, input logic flip);
    logic [FRAME_BITS-1:0] bits;
    bits = {1'b1, (~^data) ^ flip, data, 1'b0};
    repeat (FRAME_BITS)
    begin
      to_master = bits[0];
      bits      = bits >> 1;
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  // ============================================================
  // Frame decode and register access.
  // ============================================================

  initial
  begin
    byte_t data;
    logic  par;
    int    a;
    frame_count      = 0;
    parity_err_count = 0;
    armed            = 1'b0;
    wr_addr          = '0;
    for (a = 0; a < 128; a++)
      regs[a[6:0]] = a[7:0] ^ 8'h5A;
    forever
    begin
      @(negedge from_master);
      repeat (CLKS_PER_BIT / 2) @(posedge clk);
      if (!from_master)
      begin
        recv_frame(data, par);
        frame_count++;
        if (^{data, par} !== 1'b1)
          parity_err_count++;
        if (armed)
        begin
          regs[wr_addr] = data;
          armed         = 1'b0;
        end
        else if (data[7])
        begin
          armed   = 1'b1;
          wr_addr = data[6:0];
        end
        else if (!mute)
        begin
          reply_byte = regs[data[6:0]];
          -> reply_ev;
        end
      end
    end
  end

  // Reply runs on its own so decode is free again at once.
  initial
  begin
    logic flip;
    to_master = 1'b1;
    forever
    begin
      @(reply_ev);
      flip = corrupt_parity;
      // Slave turnaround of three bit times.
      repeat (3 * CLKS_PER_BIT) @(negedge clk);
      send_frame(reply_byte, flip);
    end
  end

endmodule

/* design/uart_cmd_ctrl.sv */
module uart_cmd_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_t      cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  output logic                    tx_start,
  output uart_cmd_pkg::byte_t     tx_byte,
  input  logic                    tx_done,
  output logic                    rx_en,
  input  logic                    rx_start_seen,
  input  logic                    rx_done,
  input  uart_cmd_pkg::rx_frame_t rx_frame,
  output uart_cmd_pkg::byte_t     read_data,
  output logic                    read_rdy,
  output logic                    read_err
);
  import uart_cmd_pkg::*;

  ctrl_state_t          state;
  ctrl_state_t          state_nxt;
  cmd_t                 cmd_buf;
  logic [TMR_CNT_W-1:0] tmr;
  logic                 reply_started;
  logic                 cmd_take;
  logic                 gap_over;
  logic                 timed_out;

  assign cmd_take  = cmd_vld && cmd_rdy;
  // Leaves GAP one clock early so the registered tx_start lands on time.
  assign gap_over  = (tmr == TMR_CNT_W'(GAP_CLKS - 2));
  assign timed_out = !reply_started && !rx_start_seen
                     && (tmr == TMR_CNT_W'(REPLY_TIMEOUT_CLKS - 1));

  assign rx_en    = (state == READ_WAIT);
  assign read_rdy = (state == REPORT);

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:      if (cmd_take) state_nxt = SEND_HI;
      SEND_HI:   if (tx_done) state_nxt = cmd_buf.write ? GAP : READ_WAIT;
      GAP:       if (gap_over) state_nxt = SEND_LO;
      SEND_LO:   if (tx_done) state_nxt = IDLE;
      READ_WAIT: if (rx_done || timed_out) state_nxt = REPORT;
      REPORT:    state_nxt = IDLE;
      default:   state_nxt = IDLE;
    endcase
  end

  // ============================================================
  // State, timer and outputs.
  // ============================================================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= IDLE;
      cmd_rdy       <= 1'b1;
      tx_start      <= 1'b0;
      tx_byte       <= '0;
      tmr           <= '0;
      reply_started <= 1'b0;
      read_data     <= '0;
      read_err      <= 1'b0;
    end
    else
    begin
      state    <= state_nxt;
      cmd_rdy  <= (state_nxt == IDLE);
      tx_start <= 1'b0;

      if (state == IDLE && cmd_take)
      begin
        tx_start <= 1'b1;
        tx_byte  <= {cmd_in.write, cmd_in.addr};
      end
      else if (state == GAP && gap_over)
      begin
        tx_start <= 1'b1;
        tx_byte  <= cmd_buf.data;
      end

      // One counter serves both the write gap and the reply timeout.
      if (state_nxt != state)
        tmr <= '0;
      else if ((state == GAP || state == READ_WAIT) && !reply_started)
        tmr <= tmr + 1'b1;

      if (state != READ_WAIT)
        reply_started <= 1'b0;
      else if (rx_start_seen)
        reply_started <= 1'b1;

      if (state == READ_WAIT && rx_done)
      begin
        read_data <= rx_frame.data;
        read_err  <= rx_frame.err;
      end
      else if (state == READ_WAIT && timed_out)
      begin
        read_data <= '0;
        read_err  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_take)
      cmd_buf <= cmd_in;
  end

  a_rdy_idle: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> state == IDLE);

endmodule

/* design/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // ============================================================
  // Timing.
  // ============================================================

  // Bit time is kept short for simulation; a real build sets the baud divider here.
  localparam int CLKS_PER_BIT       = 16;
  localparam int GAP_CLKS           = 16;
  localparam int REPLY_TIMEOUT_CLKS = 400;

  localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
  localparam int TMR_CNT_W = $clog2(REPLY_TIMEOUT_CLKS);

  // Start, eight data, parity, stop.
  localparam int FRAME_BITS = 11;
  localparam int BIT_IDX_W  = $clog2(FRAME_BITS);

  // ============================================================
  // Types.
  // ============================================================

  typedef logic [7:0] byte_t;
  typedef logic [6:0] addr_t;

  // High byte on the wire is {write, addr}.
  typedef struct packed {
    logic  write;
    addr_t addr;
    byte_t data;
  } cmd_t;

  typedef struct packed {
    byte_t data;
    logic  err;
  } rx_frame_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_HI,
    GAP,
    SEND_LO,
    READ_WAIT,
    REPORT
  } ctrl_state_t;

endpackage

/* design/uart_cmd_top.sv */
module uart_cmd_top (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_cmd_pkg::cmd_t  cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  input  logic                rx,
  output logic                tx,
  output uart_cmd_pkg::byte_t read_data,
  output logic                read_rdy,
  output logic                read_err
);
  import uart_cmd_pkg::*;

  logic      tx_start;
  byte_t     tx_byte;
  logic      tx_done;
  logic      rx_en;
  logic      rx_start_seen;
  logic      rx_done;
  rx_frame_t rx_frame;

  uart_cmd_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_done       (tx_done),
    .rx_en         (rx_en),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_frame      (rx_frame),
    .read_data     (read_data),
    .read_rdy      (read_rdy),
    .read_err      (read_err)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_frame u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_en         (rx_en),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_frame      (rx_frame)
  );

endmodule

/* design/uart_rx_frame.sv */
module uart_rx_frame (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  input  logic                    rx_en,
  output logic                    rx_start_seen,
  output logic                    rx_done,
  output uart_cmd_pkg::rx_frame_t rx_frame
);
  import uart_cmd_pkg::*;

  logic                 rx_meta;
  logic                 rx_sync;
  logic                 active;
  logic [BIT_CNT_W-1:0] clk_cnt;
  logic [BIT_IDX_W-1:0] bit_idx;
  logic                 bit_end;
  logic                 sample;
  byte_t                data_sh;
  logic                 par_bit;

  // Start bit is checked at half a bit; every later bit one full bit on.
  assign bit_end = (bit_idx == '0) ? (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1))
                                   : (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
  assign sample  = active && rx_en && bit_end;

  // ============================================================
  // Synchronizer and bit sequencing.
  // ============================================================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta       <= 1'b1;
      rx_sync       <= 1'b1;
      active        <= 1'b0;
      clk_cnt       <= '0;
      bit_idx       <= '0;
      rx_start_seen <= 1'b0;
      rx_done       <= 1'b0;
    end
    else
    begin
      rx_meta       <= rx;
      rx_sync       <= rx_meta;
      rx_start_seen <= 1'b0;
      rx_done       <= 1'b0;
      if (!active)
      begin
        if (rx_en && !rx_sync)
        begin
          active  <= 1'b1;
          clk_cnt <= '0;
          bit_idx <= '0;
        end
      end
      else if (!rx_en)
      begin
        active <= 1'b0;
      end
      else if (bit_end)
      begin
        clk_cnt <= '0;
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == '0)
        begin
          // Line back high at mid start bit means a glitch.
          if (rx_sync)
            active <= 1'b0;
          else
            rx_start_seen <= 1'b1;
        end
        else if (bit_idx == BIT_IDX_W'(FRAME_BITS - 1))
        begin
          active  <= 1'b0;
          rx_done <= 1'b1;
        end
      end
      else
      begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // ============================================================
  // Data capture and frame check.
  // ============================================================

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx != '0 && bit_idx <= BIT_IDX_W'(FRAME_BITS - 3))
      begin
        data_sh <= {rx_sync, data_sh[7:1]};
      end
      else if (bit_idx == BIT_IDX_W'(FRAME_BITS - 2))
      begin
        par_bit <= rx_sync;
      end
      else if (bit_idx == BIT_IDX_W'(FRAME_BITS - 1))
      begin
        rx_frame.data <= data_sh;
        // Odd parity: data plus parity must hold an odd count of ones.
        rx_frame.err  <= !(^{data_sh, par_bit}) || !rx_sync;
      end
    end
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) rx_done |=> !rx_done);

endmodule

/* design/uart_tx_frame.sv */
module uart_tx_frame (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                tx_start,
  input  uart_cmd_pkg::byte_t tx_byte,
  output logic                tx,
  output logic                tx_done
);
  import uart_cmd_pkg::*;

  logic                  busy;
  logic [FRAME_BITS-2:0] shift_reg;
  logic [BIT_CNT_W-1:0]  clk_cnt;
  logic [BIT_IDX_W-1:0]  bit_idx;
  logic                  bit_end;

  assign bit_end = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

  // Last clock of the stop bit.
  assign tx_done = busy && bit_end && (bit_idx == BIT_IDX_W'(FRAME_BITS - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy      <= 1'b0;
      tx        <= 1'b1;
      shift_reg <= '1;
      clk_cnt   <= '0;
      bit_idx   <= '0;
    end
    else if (!busy)
    begin
      if (tx_start)
      begin
        // Start bit goes out now; stop, parity and data wait in the shifter.
        busy      <= 1'b1;
        tx        <= 1'b0;
        shift_reg <= {1'b1, ~^tx_byte, tx_byte};
        clk_cnt   <= '0;
        bit_idx   <= '0;
      end
    end
    else if (bit_end)
    begin
      clk_cnt <= '0;
      if (bit_idx == BIT_IDX_W'(FRAME_BITS - 1))
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        tx        <= shift_reg[0];
        shift_reg <= {1'b1, shift_reg[FRAME_BITS-2:1]};
        bit_idx   <= bit_idx + 1'b1;
      end
    end
    else
    begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // Line must rest at mark level between frames.
  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx);

  // Controller only starts a frame once the previous one has finished.
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !busy);

endmodule

/* list.f */
design/uart_cmd_pkg.sv
design/uart_tx_frame.sv
design/uart_rx_frame.sv
design/uart_cmd_ctrl.sv
design/uart_cmd_top.sv
bench/uart_reg_model.sv
bench/uart_cmd_tb.sv
